/* files.f */
rvPkg.sv
ctrlIf.sv
pcUnit.sv
immGen.sv
regFile.sv
controller.sv
alu.sv
dataMem.sv
riscCore.sv
riscCore_properties.sv
riscCoreTb.sv

/* Makefile */
TOP = riscCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* riscCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCoreTb;

	localparam int resetCycles = 5;
	localparam int resetTimeout = 20;

	logic                       clk;
	logic                       rstN;
	logic [rvPkg::xlen-1:0]     inst;
	logic [rvPkg::xlen-1:0]     pc;
	logic                       wbEn;
	logic [rvPkg::regAddrW-1:0] wbRd;
	logic [rvPkg::xlen-1:0]     wbData;

	// stimulus table, one row per cycle
	logic [rvPkg::xlen-1:0]     rowInst[$];
	logic [rvPkg::xlen-1:0]     rowPc[$];
	logic                       rowEn[$];
	logic [rvPkg::regAddrW-1:0] rowRd[$];
	logic [rvPkg::xlen-1:0]     rowData[$];
	logic                       rowFull[$];

	logic [rvPkg::xlen-1:0] nextPc;
	int                     pcErrs;
	int                     wbErrs;
	int                     opA;
	int                     opB;
	int                     waited;

	riscCore #(
		.memWords (64)
	) i_dut (
		.clk    (clk),
		.rstN   (rstN),
		.inst   (inst),
		.pc     (pc),
		.wbEn   (wbEn),
		.wbRd   (wbRd),
		.wbData (wbData)
	);

	bind riscCore riscCore_properties uProps (
		.clk    (clk),
		.rstN   (rstN),
		.inst   (inst),
		.pc     (pc),
		.wbEn   (wbEn),
		.wbRd   (wbRd),
		.wbData (wbData),
		.regs   (uRegFile.regs)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [rvPkg::xlen-1:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvPkg::opR};
	endfunction

	function automatic logic [rvPkg::xlen-1:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// sw only
	function automatic logic [rvPkg::xlen-1:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
	endfunction

	// beq with a byte offset
	function automatic logic [rvPkg::xlen-1:0] bType(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rvPkg::opBranch};
	endfunction

	task automatic addRow(input logic [rvPkg::xlen-1:0] instr, input logic en,
			input logic [rvPkg::regAddrW-1:0] rd, input logic [rvPkg::xlen-1:0] data,
			input logic full, input logic [rvPkg::xlen-1:0] step);
		rowInst.push_back(instr);
		rowPc.push_back(nextPc);
		rowEn.push_back(en);
		rowRd.push_back(rd);
		rowData.push_back(data);
		rowFull.push_back(full);
		nextPc = nextPc + step;
	endtask

	task automatic buildTable();
		addRow(iType(opA[11:0], 5'd0, 3'b000, 5'd1, rvPkg::opImm), 1'b1, 5'd1, opA, 1'b1, 32'd4);
		addRow(iType(opB[11:0], 5'd0, 3'b000, 5'd2, rvPkg::opImm), 1'b1, 5'd2, opB, 1'b1, 32'd4);
		addRow(iType(12'd100, 5'd0, 3'b000, 5'd3, rvPkg::opImm), 1'b1, 5'd3, 32'd100, 1'b1, 32'd4);
		// x0 target shows up on the writeback but is dropped
		addRow(iType(12'd7, 5'd0, 3'b000, 5'd0, rvPkg::opImm), 1'b1, 5'd0, 32'd7, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, opA + opB, 1'b1, 32'd4);
		addRow(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, opA - opB, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 1'b1, 5'd6, opA & opB, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 1'b1, 5'd7, opA | opB, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 1'b1, 5'd8, opA ^ opB, 1'b1, 32'd4);
		// negative x2 is less than positive x1
		addRow(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), 1'b1, 5'd9, 32'd1, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd10), 1'b1, 5'd10, 32'd0, 1'b1, 32'd4);
		addRow(rType(7'h00, 5'd3, 5'd0, 3'b000, 5'd11), 1'b1, 5'd11, 32'd100, 1'b1, 32'd4);
		addRow(sType(12'd16, 5'd1, 5'd0), 1'b0, 5'd0, '0, 1'b0, 32'd4);
		addRow(sType(12'd20, 5'd2, 5'd0), 1'b0, 5'd0, '0, 1'b0, 32'd4);
		addRow(iType(12'd16, 5'd0, 3'b010, 5'd12, rvPkg::opLoad), 1'b1, 5'd12, opA, 1'b1, 32'd4);
		addRow(iType(12'd20, 5'd0, 3'b010, 5'd13, rvPkg::opLoad), 1'b1, 5'd13, opB, 1'b1, 32'd4);
		addRow(bType(13'd16, 5'd1, 5'd1), 1'b0, 5'd0, '0, 1'b0, 32'd16);
		addRow(bType(13'd8, 5'd2, 5'd1), 1'b0, 5'd0, '0, 1'b0, 32'd4);
		addRow(bType(-13'sd12, 5'd0, 5'd0), 1'b0, 5'd0, '0, 1'b0, -32'sd12);
		addRow(32'h0000_007f, 1'b0, 5'd0, '0, 1'b0, 32'd4);
		addRow(rType(7'h00, 5'd3, 5'd1, 3'b000, 5'd14), 1'b1, 5'd14, opA + 100, 1'b1, 32'd4);
	endtask

	task automatic checkPc(input logic [rvPkg::xlen-1:0] expPc, input int row);
		if (pc !== expPc) begin
			$display("Fail @%0t: row %0d pc %h, expected %h", $time, row, pc, expPc);
			pcErrs++;
		end
	endtask

	task automatic checkWb(input logic expEn, input logic [rvPkg::regAddrW-1:0] expRd,
			input logic [rvPkg::xlen-1:0] expData, input logic full, input int row);
		if (wbEn !== expEn) begin
			$display("Fail @%0t: row %0d wbEn %b, expected %b", $time, row, wbEn, expEn);
			wbErrs++;
		end else if (full && (wbRd !== expRd || wbData !== expData)) begin
			$display("Fail @%0t: row %0d writeback x%0d=%h, expected x%0d=%h",
				$time, row, wbRd, wbData, expRd, expData);
			wbErrs++;
		end
	endtask

	initial begin
		void'($urandom(50));
		rstN = 1'b0;
		inst = 32'h0000_007f;
		pcErrs = 0;
		wbErrs = 0;
		nextPc = '0;
		// addi operands, one positive and one negative
		opA = int'($urandom % 2047) + 1;
		opB = -(int'($urandom % 2047) + 1);
		buildTable();

		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
		waited = 0;
		while (pc !== '0 && waited < resetTimeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (pc !== '0) begin
			$display("timeout: pc never cleared after reset was released");
			$display("*** FAILED ***");
			$finish;
		end

		for (int i = 0; i < rowInst.size(); i++) begin
			inst = rowInst[i];
			#4;
			checkPc(rowPc[i], i);
			checkWb(rowEn[i], rowRd[i], rowData[i], rowFull[i], i);
			@(posedge clk);
			#1;
		end

		$display("pc errors: %0d, writeback errors: %0d", pcErrs, wbErrs);
		if (pcErrs + wbErrs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* riscCore_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCore_properties (
	input logic                       clk,
	input logic                       rstN,
	input logic [rvPkg::xlen-1:0]     inst,
	input logic [rvPkg::xlen-1:0]     pc,
	input logic                       wbEn,
	input logic [rvPkg::regAddrW-1:0] wbRd,
	input logic [rvPkg::xlen-1:0]     wbData,
	input logic [rvPkg::xlen-1:0]     regs [1 << rvPkg::regAddrW]
);

	pcResetZero: assert property (@(posedge clk) !rstN |=> pc == '0)
		else $error("pc not zero in the cycle after reset");

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

	// writeback to a nonzero register lands in the register file
	wbCommit: assert property (@(posedge clk) disable iff (!rstN)
		(wbEn && wbRd != '0) |=> (regs[$past(wbRd)] == $past(wbData)))
		else $error("writeback did not reach the register file");

	pcStep: assert property (@(posedge clk) disable iff (!rstN)
		(inst[6:0] != rvPkg::opBranch) |=> (pc == $past(pc) + 32'd4))
		else $error("non-branch instruction did not advance pc by 4");

endmodule

`default_nettype wire

/* riscCore.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCore #(
	parameter int memWords = 64
) (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [rvPkg::xlen-1:0]     inst,
	output logic [rvPkg::xlen-1:0]     pc,
	output logic                       wbEn,
	output logic [rvPkg::regAddrW-1:0] wbRd,
	output logic [rvPkg::xlen-1:0]     wbData
);

	rvPkg::instWord         instU;
	logic [rvPkg::xlen-1:0] imm;
	logic [rvPkg::xlen-1:0] regData1;
	logic [rvPkg::xlen-1:0] regData2;
	logic [rvPkg::xlen-1:0] srcB;
	logic [rvPkg::xlen-1:0] aluResult;
	logic [rvPkg::xlen-1:0] memRdata;
	logic                   zero;

	ctrlIf ctlBus ();

	assign instU = rvPkg::instWord'(inst);

	controller uController (
		.inst (instU),
		.ctl  (ctlBus.dec)
	);

	pcUnit uPcUnit (
		.clk  (clk),
		.rstN (rstN),
		.ctl  (ctlBus.dp),
		.zero (zero),
		.imm  (imm),
		.pc   (pc)
	);

	immGen uImmGen (
		.inst (instU),
		.imm  (imm)
	);

	regFile uRegFile (
		.clk    (clk),
		.ctl    (ctlBus.dp),
		.rs1    (instU.rFmt.rs1),
		.rs2    (instU.rFmt.rs2),
		.rd     (instU.rFmt.rd),
		.wdata  (wbData),
		.rdata1 (regData1),
		.rdata2 (regData2)
	);

	// operand b is the immediate for addi, lw and sw
	assign srcB = ctlBus.aluSrc ? imm : regData2;

	alu uAlu (
		.ctl    (ctlBus.dp),
		.srcA   (regData1),
		.srcB   (srcB),
		.result (aluResult),
		.zero   (zero)
	);

	dataMem #(
		.memWords (memWords)
	) uDataMem (
		.clk   (clk),
		.ctl   (ctlBus.dp),
		.addr  (aluResult),
		.wdata (regData2),
		.rdata (memRdata)
	);

	// writeback in progress, committed at the next edge
	assign wbData = ctlBus.memToReg ? memRdata : aluResult;
	assign wbEn = ctlBus.regWrite;
	assign wbRd = instU.rFmt.rd;

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
	parameter int memWords = 64
) (
	input  logic                   clk,
	ctrlIf.dp                      ctl,
	input  logic [rvPkg::xlen-1:0] addr,
	input  logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] rdata
);

	localparam int idxW = $clog2(memWords);

	logic [rvPkg::xlen-1:0] mem [memWords];
	logic [idxW-1:0]        idx;

	// word index above the byte offset, upper bits wrap
	assign idx = addr[idxW+1:2];

	always_ff @(posedge clk) begin
		if (ctl.memWrite) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx];

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	ctrlIf.dp                      ctl,
	input  logic [rvPkg::xlen-1:0] srcA,
	input  logic [rvPkg::xlen-1:0] srcB,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   zero
);

	always_comb begin
		case (ctl.aluCtl)
			rvPkg::aluAdd: result = srcA + srcB;
			rvPkg::aluSub: result = srcA - srcB;
			rvPkg::aluAnd: result = srcA & srcB;
			rvPkg::aluOr:  result = srcA | srcB;
			rvPkg::aluXor: result = srcA ^ srcB;
			rvPkg::aluSlt: begin
				// signed compare
				result = {{(rvPkg::xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
	input rvPkg::instWord inst,
	ctrlIf.dec            ctl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7b5;

	assign opcode = inst.rFmt.opcode;
	assign funct3 = inst.rFmt.funct3;
	assign funct7b5 = inst.rFmt.funct7[5];

	always_comb begin
		// anything not matched below is a nop
		ctl.regWrite = 1'b0;
		ctl.aluSrc = 1'b0;
		ctl.memWrite = 1'b0;
		ctl.memToReg = 1'b0;
		ctl.branch = 1'b0;
		ctl.aluCtl = rvPkg::aluAdd;

		case (opcode)
			rvPkg::opR: begin
				ctl.regWrite = 1'b1;
				case ({funct7b5, funct3})
					4'b0000: ctl.aluCtl = rvPkg::aluAdd;
					4'b1000: ctl.aluCtl = rvPkg::aluSub;
					4'b0010: ctl.aluCtl = rvPkg::aluSlt;
					4'b0100: ctl.aluCtl = rvPkg::aluXor;
					4'b0110: ctl.aluCtl = rvPkg::aluOr;
					4'b0111: ctl.aluCtl = rvPkg::aluAnd;
					default: ctl.regWrite = 1'b0;
				endcase
			end
			rvPkg::opImm: begin
				// addi only
				ctl.regWrite = (funct3 == 3'b000);
				ctl.aluSrc = 1'b1;
			end
			rvPkg::opLoad: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrc = 1'b1;
				ctl.memToReg = 1'b1;
			end
			rvPkg::opStore: begin
				ctl.aluSrc = 1'b1;
				ctl.memWrite = 1'b1;
			end
			rvPkg::opBranch: begin
				// beq compares by subtraction
				ctl.branch = (funct3 == 3'b000);
				ctl.aluCtl = rvPkg::aluSub;
			end
			default: begin
				ctl.regWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                       clk,
	ctrlIf.dp                          ctl,
	input  logic [rvPkg::regAddrW-1:0] rs1,
	input  logic [rvPkg::regAddrW-1:0] rs2,
	input  logic [rvPkg::regAddrW-1:0] rd,
	input  logic [rvPkg::xlen-1:0]     wdata,
	output logic [rvPkg::xlen-1:0]     rdata1,
	output logic [rvPkg::xlen-1:0]     rdata2
);

	localparam int numRegs = 1 << rvPkg::regAddrW;

	logic [rvPkg::xlen-1:0] regs [numRegs];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (ctl.regWrite && (rd != '0)) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* immGen.sv */
`timescale 1ns/1ps
`default_nettype none

module immGen (
	input  rvPkg::instWord         inst,
	output logic [rvPkg::xlen-1:0] imm
);

	always_comb begin
		case (inst.iFmt.opcode)
			rvPkg::opImm, rvPkg::opLoad: begin
				imm = {{20{inst.iFmt.imm[11]}}, inst.iFmt.imm};
			end
			rvPkg::opStore: begin
				imm = {{20{inst.sbFmt.immHi[6]}}, inst.sbFmt.immHi, inst.sbFmt.immLo};
			end
			rvPkg::opBranch: begin
				// bit 11 of the offset sits in the low bit of immLo
				imm = {
					{19{inst.sbFmt.immHi[6]}},
					inst.sbFmt.immHi[6],
					inst.sbFmt.immLo[0],
					inst.sbFmt.immHi[5:0],
					inst.sbFmt.immLo[4:1],
					1'b0
				};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
	input  logic                   clk,
	input  logic                   rstN,
	ctrlIf.dp                      ctl,
	input  logic                   zero,
	input  logic [rvPkg::xlen-1:0] imm,
	output logic [rvPkg::xlen-1:0] pc
);

	logic [rvPkg::xlen-1:0] pcPlus4;
	logic [rvPkg::xlen-1:0] pcBranch;
	logic [rvPkg::xlen-1:0] pcNext;
	logic                   pcSrc;

	assign pcPlus4 = pc + rvPkg::xlen'(4);
	assign pcBranch = pc + imm;

	// beq taken when operands compare equal
	assign pcSrc = ctl.branch & zero;
	assign pcNext = pcSrc ? pcBranch : pcPlus4;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

/* ctrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

	logic        regWrite;
	// high selects the immediate as alu operand b
	logic        aluSrc;
	logic        memWrite;
	logic        memToReg;
	logic        branch;
	rvPkg::aluOp aluCtl;

	modport dec (
		output regWrite,
		output aluSrc,
		output memWrite,
		output memToReg,
		output branch,
		output aluCtl
	);

	modport dp (
		input regWrite,
		input aluSrc,
		input memWrite,
		input memToReg,
		input branch,
		input aluCtl
	);

endinterface

`default_nettype wire

/* rvPkg.sv */
`default_nettype none

package rvPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// supported opcode classes
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;

	// alu control, laid out as {funct7[5], funct3}
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b1000,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111
	} aluOp;

	typedef struct packed {
		logic [6:0]          funct7;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rs1;
		logic [2:0]          funct3;
		logic [regAddrW-1:0] rd;
		logic [6:0]          opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0]         imm;
		logic [regAddrW-1:0] rs1;
		logic [2:0]          funct3;
		logic [regAddrW-1:0] rd;
		logic [6:0]          opcode;
	} iFmtT;

	// store and branch share this split immediate layout
	typedef struct packed {
		logic [6:0]          immHi;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rs1;
		logic [2:0]          funct3;
		logic [4:0]          immLo;
		logic [6:0]          opcode;
	} sbFmtT;

	typedef union packed {
		rFmtT  rFmt;
		iFmtT  iFmt;
		sbFmtT sbFmt;
	} instWord;

endpackage

`default_nettype wire
